//--- radix4_divider.f
hdl/div_pkg.sv
hdl/radix4_digit.sv
hdl/radix4_stage.sv
hdl/div_control.sv
hdl/div_datapath.sv
hdl/radix4_divider.sv
sim/div_clock_gen.sv
sim/div_chk.sv
sim/div_tb.sv

//--- Bender.yml
package:
  name: radix4_divider

sources:
  - files:
      - hdl/div_pkg.sv
      - hdl/radix4_digit.sv
      - hdl/radix4_stage.sv
      - hdl/div_control.sv
      - hdl/div_datapath.sv
      - hdl/radix4_divider.sv
  - target: test
    files:
      - sim/div_clock_gen.sv
      - sim/div_chk.sv
      - sim/div_tb.sv

//--- sim/div_tb.sv
// Testbench top: directed divider tests, value check, watchdog and summary

module div_tb;

    localparam int WIDTH            = div_pkg::DEFAULT_WIDTH;
    localparam int DIGITS_PER_CYCLE = div_pkg::DEFAULT_DIGITS_PER_CYCLE;
    localparam int ITERATIONS       = WIDTH / (div_pkg::RADIX_BITS * DIGITS_PER_CYCLE);
    localparam int LATENCY          = ITERATIONS + 1;
    localparam int NUM_RANDOM       = 50;
    // Directed, random, back to back, busy trigger, divide by zero
    localparam int NUM_OPS          = 5 + NUM_RANDOM + 2 + 1 + 2;
    localparam int TIMEOUT_CYCLES   = NUM_OPS * (ITERATIONS + 4) + 100;
    localparam logic [WIDTH-1:0] MAX_VALUE = '1;

    logic             ctl_clk;
    logic             reset;
    logic             trigger;
    logic [WIDTH-1:0] dividend;
    logic [WIDTH-1:0] divisor;
    logic             ready;
    logic             done;
    logic [WIDTH-1:0] quotient;
    logic [WIDTH-1:0] remainder;

    int          errors;
    int unsigned cycle_count = 0;
    int unsigned accept_stamp;
    integer      seed;

    div_clock_gen #(
        .PERIOD       (20),
        .RESET_CYCLES (16)
    ) u_clock_gen (
        .ctl_clk (ctl_clk),
        .reset   (reset)
    );

    radix4_divider dut0 (
        .ctl_clk   (ctl_clk),
        .reset     (reset),
        .trigger   (trigger),
        .dividend  (dividend),
        .divisor   (divisor),
        .ready     (ready),
        .done      (done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    always @(posedge ctl_clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Divide by zero selects digit 3 everywhere
    function automatic logic [WIDTH-1:0] expected_quotient(input logic [WIDTH-1:0] a,
                                                           input logic [WIDTH-1:0] b);
        if (b == '0) begin
            return MAX_VALUE;
        end
        return a / b;
    endfunction

    function automatic logic [WIDTH-1:0] expected_remainder(input logic [WIDTH-1:0] a,
                                                            input logic [WIDTH-1:0] b);
        if (b == '0) begin
            return a;
        end
        return a % b;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED: %s expected %h actual %h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic drive_op(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
        @(posedge ctl_clk);
        trigger  <= 1'b1;
        dividend <= a;
        divisor  <= b;
        @(negedge ctl_clk);
    endtask

    // Called at a falling edge, returns on the accepting edge
    task automatic accept_edge();
        if (ready !== 1'b1) begin
            errors++;
            $display("DUT was not ready when an operation was started at %0t", $time);
        end
        accept_stamp = cycle_count;
        @(posedge ctl_clk);
    endtask

    task automatic send_op(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
        drive_op(a, b);
        accept_edge();
        trigger <= 1'b0;
    endtask

    task automatic wait_done(output int unsigned latency);
        int waited;
        waited = 0;
        do begin
            @(negedge ctl_clk);
            waited++;
        end while (done !== 1'b1 && waited < 4 * LATENCY);
        if (done !== 1'b1) begin
            errors++;
            $display("No done pulse within %0d cycles of starting an operation", waited);
        end
        latency = cycle_count - accept_stamp - 1;
    endtask

    task automatic check_result(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
        check_value("quotient", expected_quotient(a, b), quotient);
        check_value("remainder", expected_remainder(a, b), remainder);
    endtask

    task automatic run_pair(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
        int unsigned latency;
        send_op(a, b);
        wait_done(latency);
        check_value("latency", LATENCY, latency);
        check_result(a, b);
    endtask

    task automatic test_reset_values();
        check_value("ready", 1, ready);
        check_value("done", 0, done);
        check_value("quotient", 0, quotient);
        check_value("remainder", 0, remainder);
    endtask

    task automatic test_directed();
        run_pair(32'd100, 32'd7);
        run_pair(MAX_VALUE, 32'd1);
        run_pair(MAX_VALUE, MAX_VALUE);
        run_pair(32'd5, 32'hF000_0000);
        run_pair(32'd3 * 32'd12345 + 32'd2, 32'd12345);
    endtask

    task automatic test_random();
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            a = $random(seed);
            b = $random(seed);
            if (i % 4 == 0) begin
                b[WIDTH-1] = 1'b1;
            end else if (i % 4 == 1) begin
                // Small divisors give long quotients
                b = b >> (WIDTH - 8);
            end
            if (b == '0) begin
                b = 1;
            end
            run_pair(a, b);
        end
    endtask

    task automatic test_back_to_back();
        int unsigned latency;
        drive_op(32'd1000, 32'd33);
        accept_edge();
        // Second operands wait with trigger held high
        dividend <= 32'hDEAD_BEEF;
        divisor  <= 32'd17;
        wait_done(latency);
        check_value("latency", LATENCY, latency);
        check_result(32'd1000, 32'd33);
        accept_edge();
        trigger <= 1'b0;
        wait_done(latency);
        check_value("latency", LATENCY, latency);
        check_result(32'hDEAD_BEEF, 32'd17);
    endtask

    task automatic test_busy_trigger();
        int unsigned latency;
        send_op(32'h0012_3456, 32'd99);
        repeat (2) @(posedge ctl_clk);
        trigger  <= 1'b1;
        dividend <= 32'hFFFF_0000;
        divisor  <= 32'd3;
        @(negedge ctl_clk);
        check_value("ready", 0, ready);
        @(posedge ctl_clk);
        trigger <= 1'b0;
        wait_done(latency);
        check_value("latency", LATENCY, latency);
        check_result(32'h0012_3456, 32'd99);
        // Ignored trigger must not start a second run
        @(negedge ctl_clk);
        check_value("done", 0, done);
        check_value("ready", 1, ready);
    endtask

    task automatic test_divide_by_zero();
        run_pair(32'h1357_9BDF, 32'd0);
        run_pair(32'd42, 32'd0);
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge ctl_clk);
        $display("Watchdog timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors: %0d", errors);
        $display("Something failed");
        $finish;
    end

    initial begin
        errors   = 0;
        seed     = 32'h8a43;
        trigger  = 1'b0;
        dividend = '0;
        divisor  = '0;
        wait (reset === 1'b1);
        @(negedge ctl_clk);
        test_reset_values();
        test_directed();
        test_random();
        test_back_to_back();
        test_busy_trigger();
        test_divide_by_zero();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- sim/div_chk.sv
// Handshake assertions for the radix-4 divider and their bind to the top level

module div_chk #(
    parameter int WIDTH            = 32,
    parameter int DIGITS_PER_CYCLE = 2
) (
    input logic             ctl_clk,
    input logic             reset,
    input logic             trigger,
    input logic             ready,
    input logic             done,
    input logic [WIDTH-1:0] quotient
);

    localparam int ITERATIONS  = WIDTH / (div_pkg::RADIX_BITS * DIGITS_PER_CYCLE);
    localparam int BUSY_CYCLES = ITERATIONS + 1;

    done_pulse: assert property (
        @(posedge ctl_clk) disable iff (!reset) done |=> !done
    ) else $error("done stayed high for more than one cycle");

    ready_low_in_reset: assert property (
        @(posedge ctl_clk) !reset |-> !ready
    ) else $error("ready was high during reset");

    done_low_in_reset: assert property (
        @(posedge ctl_clk) !reset |=> !done
    ) else $error("done was high during reset");

    // Busy from the edge after acceptance until the done cycle
    busy_until_done: assert property (
        @(posedge ctl_clk) disable iff (!reset)
        (trigger && ready) |=> (!ready) [*BUSY_CYCLES] ##1 (ready && done)
    ) else $error("ready or done broke the fixed latency after acceptance");

    quotient_hold: assert property (
        @(posedge ctl_clk) disable iff (!reset) !$rose(done) |-> $stable(quotient)
    ) else $error("quotient changed outside a done pulse");

endmodule

bind radix4_divider div_chk #(
    .WIDTH            (WIDTH),
    .DIGITS_PER_CYCLE (DIGITS_PER_CYCLE)
) u_chk (
    .ctl_clk  (ctl_clk),
    .reset    (reset),
    .trigger  (trigger),
    .ready    (ready),
    .done     (done),
    .quotient (quotient)
);

//--- sim/div_clock_gen.sv
// Testbench clock and reset generator

module div_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic ctl_clk,
    output logic reset
);

    initial begin
        ctl_clk = 1'b0;
        forever #(PERIOD / 2) ctl_clk = ~ctl_clk;
    end

    // Active low, released on a rising edge
    initial begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge ctl_clk);
        reset <= 1'b1;
    end

endmodule

//--- hdl/radix4_divider.sv
// Radix-4 iterative unsigned divider top level: control, datapath and stage

module radix4_divider #(
    parameter int WIDTH            = div_pkg::DEFAULT_WIDTH,
    parameter int DIGITS_PER_CYCLE = div_pkg::DEFAULT_DIGITS_PER_CYCLE
) (
    input  logic             ctl_clk,
    input  logic             reset,
    input  logic             trigger,
    input  logic [WIDTH-1:0] dividend,
    input  logic [WIDTH-1:0] divisor,
    output logic             ready,
    output logic             done,
    output logic [WIDTH-1:0] quotient,
    output logic [WIDTH-1:0] remainder
);

    logic               load;
    logic               step;
    logic               finish;
    logic [2*WIDTH-1:0] calc_word;
    logic [2*WIDTH-1:0] next_word;
    logic [WIDTH-1:0]   divisor_q;

    div_control #(
        .WIDTH            (WIDTH),
        .DIGITS_PER_CYCLE (DIGITS_PER_CYCLE)
    ) u_control (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .trigger (trigger),
        .ready   (ready),
        .done    (done),
        .load    (load),
        .step    (step),
        .finish  (finish)
    );

    div_datapath #(
        .WIDTH (WIDTH)
    ) u_datapath (
        .ctl_clk   (ctl_clk),
        .reset     (reset),
        .load      (load),
        .step      (step),
        .finish    (finish),
        .dividend  (dividend),
        .divisor   (divisor),
        .next_word (next_word),
        .calc_word (calc_word),
        .divisor_q (divisor_q),
        .quotient  (quotient),
        .remainder (remainder)
    );

    radix4_stage #(
        .WIDTH            (WIDTH),
        .DIGITS_PER_CYCLE (DIGITS_PER_CYCLE)
    ) u_stage (
        .calc_word (calc_word),
        .divisor_q (divisor_q),
        .next_word (next_word)
    );

endmodule

//--- hdl/div_datapath.sv
// Divider datapath: divisor register, calculation register, result registers

module div_datapath #(
    parameter int WIDTH = 32
) (
    input  logic               ctl_clk,
    input  logic               reset,
    input  logic               load,
    input  logic               step,
    input  logic               finish,
    input  logic [WIDTH-1:0]   dividend,
    input  logic [WIDTH-1:0]   divisor,
    input  logic [2*WIDTH-1:0] next_word,
    output logic [2*WIDTH-1:0] calc_word,
    output logic [WIDTH-1:0]   divisor_q,
    output logic [WIDTH-1:0]   quotient,
    output logic [WIDTH-1:0]   remainder
);

    // Remainder in the high half, dividend turning into quotient in the low half
    always_ff @(posedge ctl_clk) begin
        if (load) begin
            divisor_q <= divisor;
            calc_word <= {{WIDTH{1'b0}}, dividend};
        end else if (step) begin
            calc_word <= next_word;
        end
    end

    // Results hold until the next operation finishes
    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            quotient  <= '0;
            remainder <= '0;
        end else if (finish) begin
            quotient  <= calc_word[WIDTH-1:0];
            remainder <= calc_word[2*WIDTH-1:WIDTH];
        end
    end

endmodule

//--- hdl/div_control.sv
// Divider control: state machine, iteration counter, ready and done

module div_control #(
    parameter int WIDTH            = 32,
    parameter int DIGITS_PER_CYCLE = 2
) (
    input  logic ctl_clk,
    input  logic reset,
    input  logic trigger,
    output logic ready,
    output logic done,
    output logic load,
    output logic step,
    output logic finish
);

    localparam int ITERATIONS = WIDTH / (div_pkg::RADIX_BITS * DIGITS_PER_CYCLE);
    localparam int CNT_BITS   = $clog2(ITERATIONS + 1);
    localparam logic [CNT_BITS-1:0] LAST = CNT_BITS'(ITERATIONS);

    div_pkg::div_state_t state;
    logic [CNT_BITS-1:0] count;

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            state <= div_pkg::IDLE;
            count <= '0;
        end else begin
            case (state)
                div_pkg::IDLE: begin
                    if (trigger) begin
                        state <= div_pkg::CALC;
                        count <= '0;
                    end
                end
                div_pkg::CALC: begin
                    if (count == LAST) begin
                        state <= div_pkg::DONE;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                div_pkg::DONE: begin
                    // Back to back when trigger arrives with done
                    if (trigger) begin
                        state <= div_pkg::CALC;
                        count <= '0;
                    end else begin
                        state <= div_pkg::IDLE;
                    end
                end
                default: begin
                    state <= div_pkg::IDLE;
                end
            endcase
        end
    end

    // Not ready while reset is held
    assign ready = reset && ((state == div_pkg::IDLE) || (state == div_pkg::DONE));
    assign done  = (state == div_pkg::DONE);
    assign load  = ready && trigger;

    // Counted cycles 0 to ITERATIONS-1 advance, the last one registers results
    assign step   = (state == div_pkg::CALC) && (count != LAST);
    assign finish = (state == div_pkg::CALC) && (count == LAST);

endmodule

//--- hdl/radix4_stage.sv
// One clock of division work: divisor multiples and a chain of digit steps

module radix4_stage #(
    parameter int WIDTH            = 32,
    parameter int DIGITS_PER_CYCLE = 2
) (
    input  logic [2*WIDTH-1:0] calc_word,
    input  logic [WIDTH-1:0]   divisor_q,
    output logic [2*WIDTH-1:0] next_word
);

    localparam int RB      = div_pkg::RADIX_BITS;
    localparam int Q_BITS  = RB * DIGITS_PER_CYCLE;

    logic [WIDTH+1:0]  multiple_1;
    logic [WIDTH+1:0]  multiple_2;
    logic [WIDTH+1:0]  multiple_3;
    logic [WIDTH-1:0]  rem_chain [0:DIGITS_PER_CYCLE];
    logic [Q_BITS-1:0] q_digits;

    // Full width so no multiple gets truncated
    assign multiple_1 = {2'b00, divisor_q};
    assign multiple_2 = {1'b0, divisor_q, 1'b0};
    assign multiple_3 = multiple_1 + multiple_2;

    assign rem_chain[0] = calc_word[2*WIDTH-1:WIDTH];

    // Top dividend bits first
    for (genvar j = 0; j < DIGITS_PER_CYCLE; j++) begin : g_digit
        radix4_digit #(
            .WIDTH (WIDTH)
        ) u_digit (
            .partial_rem   (rem_chain[j]),
            .dividend_bits (calc_word[WIDTH-1-RB*j -: RB]),
            .multiple_1    (multiple_1),
            .multiple_2    (multiple_2),
            .multiple_3    (multiple_3),
            .new_rem       (rem_chain[j+1]),
            .q_digit       (q_digits[RB*(DIGITS_PER_CYCLE-j)-1 -: RB])
        );
    end

    // Remainder, unused dividend bits moved up, new quotient digits at the bottom
    assign next_word = {rem_chain[DIGITS_PER_CYCLE], calc_word[WIDTH-1-Q_BITS:0], q_digits};

endmodule

//--- hdl/radix4_digit.sv
// Single radix-4 digit step: three trial subtractions and priority select

module radix4_digit #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]                partial_rem,
    input  logic [div_pkg::RADIX_BITS-1:0]  dividend_bits,
    input  logic [WIDTH+1:0]                multiple_1,
    input  logic [WIDTH+1:0]                multiple_2,
    input  logic [WIDTH+1:0]                multiple_3,
    output logic [WIDTH-1:0]                new_rem,
    output logic [div_pkg::RADIX_BITS-1:0]  q_digit
);

    logic [WIDTH+1:0] shifted;
    logic [WIDTH+2:0] diff_1;
    logic [WIDTH+2:0] diff_2;
    logic [WIDTH+2:0] diff_3;
    logic             fit_1;
    logic             fit_2;
    logic             fit_3;

    // Bring down the next two dividend bits
    assign shifted = {partial_rem, dividend_bits};

    // One guard bit catches the borrow
    assign diff_1 = {1'b0, shifted} - {1'b0, multiple_1};
    assign diff_2 = {1'b0, shifted} - {1'b0, multiple_2};
    assign diff_3 = {1'b0, shifted} - {1'b0, multiple_3};

    assign fit_1 = ~diff_1[WIDTH+2];
    assign fit_2 = ~diff_2[WIDTH+2];
    assign fit_3 = ~diff_3[WIDTH+2];

    // Largest multiple that fits wins
    always_comb begin
        if (fit_3) begin
            new_rem = diff_3[WIDTH-1:0];
            q_digit = 2'h3;
        end else if (fit_2) begin
            new_rem = diff_2[WIDTH-1:0];
            q_digit = 2'h2;
        end else if (fit_1) begin
            new_rem = diff_1[WIDTH-1:0];
            q_digit = 2'h1;
        end else begin
            // Partial remainder is below the divisor here, so it fits
            new_rem = shifted[WIDTH-1:0];
            q_digit = 2'h0;
        end
    end

endmodule

//--- hdl/div_pkg.sv
// Divider package: default sizes, radix constants, control state type

package div_pkg;

    // Default operand width in bits
    localparam int DEFAULT_WIDTH = 32;

    // Radix-4 digits retired per clock
    localparam int DEFAULT_DIGITS_PER_CYCLE = 2;

    // Quotient bits per radix-4 digit
    localparam int RADIX_BITS = 2;

    // Control states
    typedef enum logic [1:0] {
        IDLE = 2'h0,
        CALC = 2'h1,
        DONE = 2'h2
    } div_state_t;

endpackage
